// File: sim.f
+incdir+source
source/neoIoPkg.sv
source/systemLatch.sv
source/busDecode.sv
source/ioRegisters.sv
source/busResponse.sv
source/neoIoTop.sv
testbench/tbNeoIo.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbNeoIo
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tbNeoIo.sv
`timescale 1ns/1ps

`include "neoIoSettings.svh"

module tbNeoIo;
	import neoIoPkg::*;

	// Word addresses, the byte address shifted right by one
	localparam logic [`ADDR_WIDTH-1:0] P1DIP_ADDR = 23'h180000;
	localparam logic [`ADDR_WIDTH-1:0] STATUSA_ADDR = 23'h190000;
	localparam logic [`ADDR_WIDTH-1:0] P2_ADDR = 23'h1A0000;
	localparam logic [`ADDR_WIDTH-1:0] STATUSB_ADDR = 23'h1C0000;
	localparam logic [`ADDR_WIDTH-1:0] SYSLATCH_ADDR = 23'h1D0000;
	localparam logic [`ADDR_WIDTH-1:0] UNMAPPED_ADDR = 23'h020000;
	// Bit-write registers at 0x380001, 0x380011 and up
	localparam logic [`ADDR_WIDTH-1:0] POUTPUT_ADDR = 23'h1C0000;
	localparam logic [`ADDR_WIDTH-1:0] CRDBANK_ADDR = 23'h1C0008;
	localparam logic [`ADDR_WIDTH-1:0] SLOT_ADDR = 23'h1C0010;
	localparam logic [`ADDR_WIDTH-1:0] LEDLATCH_ADDR = 23'h1C0018;
	localparam logic [`ADDR_WIDTH-1:0] LEDDATA_ADDR = 23'h1C0020;
	localparam int ACK_TIMEOUT = 40;

	logic CLK_24M = 1'b0;
	logic arstN;
	logic hostReq;
	logic hostAck;
	busCmdT hostCmd;
	busRspT hostRsp;
	logic [`JOY_WIDTH-1:0] p1In, p2In;
	logic [`DIP_WIDTH-1:0] dipSw;
	logic testBtn;
	logic [2:0] p1Out, p2Out, cardBank, slot, ledLatch;
	logic [7:0] ledData;
	logic [1:0] counters, lockouts;
	sysFlagsT sysFlags;

	// Model of every output register
	logic [2:0] expP1Out, expP2Out, expCardBank, expSlot, expLedLatch;
	logic [7:0] expLedData;
	logic [1:0] expCounters, expLockouts;
	logic [7:0] expFlags;

	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsAtStart = 0;
	string testName;
	bit timedOut = 1'b0;

	neoIoTop UUT (.CLK_24M, .arstN, .hostReq, .hostAck, .hostCmd, .hostRsp,
		.p1In, .p2In, .dipSw, .testBtn, .p1Out, .p2Out, .cardBank, .slot,
		.ledLatch, .ledData, .counters, .lockouts, .sysFlags);

	// 4 ns period
	always #2 CLK_24M = ~CLK_24M;

	task automatic checkBits(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkRsp(input string name, input busRspT got, input busRspT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got hit 0x%h data 0x%h, expected hit 0x%h data 0x%h",
				name, got.hit, got.rdData, exp.hit, exp.rdData);
		end
	endtask

	task automatic checkFlags(input string name, input sysFlagsT got, input sysFlagsT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Every output against the model, so a write touches only its own register
	task automatic checkOutputs();
		checkBits("p1Out", {5'b0, p1Out}, {5'b0, expP1Out});
		checkBits("p2Out", {5'b0, p2Out}, {5'b0, expP2Out});
		checkBits("cardBank", {5'b0, cardBank}, {5'b0, expCardBank});
		checkBits("slot", {5'b0, slot}, {5'b0, expSlot});
		checkBits("ledLatch", {5'b0, ledLatch}, {5'b0, expLedLatch});
		checkBits("ledData", ledData, expLedData);
		checkBits("counters", {6'b0, counters}, {6'b0, expCounters});
		checkBits("lockouts", {6'b0, lockouts}, {6'b0, expLockouts});
		checkFlags("sysFlags", sysFlags, sysFlagsT'(expFlags));
	endtask

	task automatic beginTest(input string name);
		testName = name;
		errorsAtStart = errors;
	endtask

	task automatic endTest();
		testsRun++;
		if (errors == errorsAtStart) begin
			$display("test %0d %s: ok", testsRun, testName);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, testName, errors - errorsAtStart);
		end
	endtask

	function automatic busCmdT makeCmd(input logic [`ADDR_WIDTH-1:0] addr, input logic write,
		input logic upperStrobe, input logic lowerStrobe, input logic [`DATA_WIDTH-1:0] data);
		makeCmd.addr = addr;
		makeCmd.write = write;
		makeCmd.upperStrobe = upperStrobe;
		makeCmd.lowerStrobe = lowerStrobe;
		makeCmd.wrData = data;
	endfunction

	// Counter area is A6 and A5 high, then A4 set, A2 lockout, A1 player 2
	function automatic logic [`ADDR_WIDTH-1:0] counterAddr(input logic setBit,
		input logic lockSel, input logic playerSel);
		counterAddr = STATUSB_ADDR | 23'h30 | {19'h0, setBit, 1'b0, lockSel, playerSel};
	endfunction

	// A4 carries the flag value, A3 to A1 the flag index
	function automatic logic [`ADDR_WIDTH-1:0] latchAddr(input logic value,
		input logic [2:0] idx);
		latchAddr = SYSLATCH_ADDR | {19'h0, value, idx};
	endfunction

	// One four-phase exchange on the host port
	// holdCycles keeps hostReq up after hostAck and watches the response
	task automatic busAccess(input busCmdT cmd, input int holdCycles, output busRspT rsp);
		int waitCount;
		int holdCount;
		rsp = '0;
		@(posedge CLK_24M);
		hostCmd <= cmd;
		hostReq <= 1'b1;
		waitCount = 0;
		@(posedge CLK_24M);
		while (!hostAck && waitCount < ACK_TIMEOUT) begin
			@(posedge CLK_24M);
			waitCount++;
		end
		if (!hostAck) begin
			$display("Timeout: hostAck never rose for address 0x%h", cmd.addr);
			errors++;
			timedOut = 1'b1;
			hostReq <= 1'b0;
		end else begin
			rsp = hostRsp;
			for (holdCount = 0; holdCount < holdCycles; holdCount++) begin
				@(posedge CLK_24M);
				checkBits("hostAck held", {7'b0, hostAck}, 8'h01);
				checkRsp("hostRsp held", hostRsp, rsp);
			end
			hostReq <= 1'b0;
			waitCount = 0;
			@(posedge CLK_24M);
			while (hostAck && waitCount < ACK_TIMEOUT) begin
				@(posedge CLK_24M);
				waitCount++;
			end
			if (hostAck) begin
				$display("Timeout: hostAck stayed high after hostReq fell");
				errors++;
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic readWord(input logic [`ADDR_WIDTH-1:0] addr, output busRspT rsp);
		busAccess(makeCmd(addr, 1'b0, 1'b1, 1'b1, 16'h0000), 0, rsp);
	endtask

	// Bit-writes and latch writes go on the lower byte
	task automatic writeLow(input logic [`ADDR_WIDTH-1:0] addr, input logic [7:0] data);
		busRspT rsp;
		busAccess(makeCmd(addr, 1'b1, 1'b0, 1'b1, {8'h00, data}), 0, rsp);
	endtask

	task automatic resetValues();
		beginTest("reset values");
		{expP1Out, expP2Out, expCardBank, expSlot, expLedLatch} = '0;
		{expLedData, expCounters, expLockouts, expFlags} = '0;
		checkOutputs();
		checkBits("hostAck", {7'b0, hostAck}, 8'h00);
		endTest();
	endtask

	task automatic readInputs();
		logic [31:0] rnd;
		logic [`JOY_WIDTH-1:0] p1, p2;
		logic [`DIP_WIDTH-1:0] dip;
		logic btn;
		busRspT rsp;
		busRspT expRsp;
		beginTest("input reads");
		repeat (4) begin
			rnd = $urandom;
			p1 = rnd[`JOY_WIDTH-1:0];
			rnd = $urandom;
			p2 = rnd[`JOY_WIDTH-1:0];
			rnd = $urandom;
			dip = rnd[`DIP_WIDTH-1:0];
			btn = rnd[31];
			@(posedge CLK_24M);
			p1In <= p1;
			p2In <= p2;
			dipSw <= dip;
			testBtn <= btn;
			expRsp.hit = 1'b1;
			// P1CNT on the upper lane, DIP switches on the lower
			expRsp.rdData = {p1[7:0], dip};
			readWord(P1DIP_ADDR, rsp);
			checkRsp("P1CNT/DIPSW", rsp, expRsp);
			// Only bit 7 is driven, and the button pulls it low
			expRsp.rdData = 16'hFFFF;
			expRsp.rdData[7] = !btn;
			readWord(STATUSA_ADDR, rsp);
			checkRsp("STATUS_A", rsp, expRsp);
			expRsp.rdData = {p2[7:0], 8'hFF};
			readWord(P2_ADDR, rsp);
			checkRsp("P2CNT", rsp, expRsp);
			// Extra joypad bits, player 2 on top
			expRsp.rdData = 16'hFFFF;
			expRsp.rdData[15:14] = p2[9:8];
			expRsp.rdData[13:12] = p1[9:8];
			readWord(STATUSB_ADDR, rsp);
			checkRsp("STATUS_B", rsp, expRsp);
		end
		endTest();
	endtask

	task automatic bitWrites();
		logic [31:0] rnd;
		beginTest("bit-write registers");
		repeat (2) begin
			rnd = $urandom;
			writeLow(POUTPUT_ADDR, rnd[7:0]);
			expP1Out = rnd[2:0];
			expP2Out = rnd[5:3];
			checkOutputs();
			writeLow(CRDBANK_ADDR, rnd[15:8]);
			expCardBank = rnd[10:8];
			checkOutputs();
			writeLow(SLOT_ADDR, rnd[23:16]);
			expSlot = rnd[18:16];
			checkOutputs();
			// LED latch bits sit at 5:3
			writeLow(LEDLATCH_ADDR, rnd[31:24]);
			expLedLatch = rnd[29:27];
			checkOutputs();
			rnd = $urandom;
			writeLow(LEDDATA_ADDR, rnd[7:0]);
			expLedData = rnd[7:0];
			checkOutputs();
		end
		endTest();
	endtask

	task automatic counterCommands();
		int sel;
		beginTest("counter and lockout");
		// Set all four one by one, then clear them one by one
		for (sel = 0; sel < 4; sel++) begin
			writeLow(counterAddr(1'b1, sel[1], sel[0]), 8'h00);
			if (sel[1])
				expLockouts[sel[0]] = 1'b1;
			else
				expCounters[sel[0]] = 1'b1;
			checkOutputs();
		end
		for (sel = 0; sel < 4; sel++) begin
			writeLow(counterAddr(1'b0, sel[1], sel[0]), 8'h00);
			if (sel[1])
				expLockouts[sel[0]] = 1'b0;
			else
				expCounters[sel[0]] = 1'b0;
			checkOutputs();
		end
		endTest();
	endtask

	task automatic systemLatchWrites();
		logic [31:0] rnd;
		beginTest("system latch");
		repeat (16) begin
			rnd = $urandom;
			writeLow(latchAddr(rnd[3], rnd[2:0]), rnd[15:8]);
			expFlags[rnd[2:0]] = rnd[3];
			checkOutputs();
		end
		endTest();
	endtask

	task automatic unmappedAndStall();
		logic [31:0] rnd;
		busRspT rsp;
		busRspT expRsp;
		beginTest("unmapped and stall");
		expRsp.hit = 1'b0;
		expRsp.rdData = `OPEN_BUS;
		readWord(UNMAPPED_ADDR, rsp);
		checkRsp("unmapped read", rsp, expRsp);
		rnd = $urandom;
		// Same low bits as LEDDATA, outside every zone
		writeLow(UNMAPPED_ADDR | 23'h20, rnd[7:0]);
		checkOutputs();
		@(posedge CLK_24M);
		dipSw <= rnd[15:8];
		busAccess(makeCmd(P1DIP_ADDR, 1'b0, 1'b1, 1'b1, 16'h0000), 20, rsp);
		expRsp.hit = 1'b1;
		expRsp.rdData = {p1In[7:0], rnd[15:8]};
		checkRsp("stalled read", rsp, expRsp);
		endTest();
	endtask

	initial begin
		void'($urandom(32'h383b2c2d));
		arstN <= 1'b0;
		hostReq <= 1'b0;
		hostCmd <= '0;
		p1In <= '0;
		p2In <= '0;
		dipSw <= '0;
		testBtn <= 1'b0;
		repeat (16) @(posedge CLK_24M);
		arstN <= 1'b1;
		@(posedge CLK_24M);
		resetValues();
		if (!timedOut)
			readInputs();
		if (!timedOut)
			bitWrites();
		if (!timedOut)
			counterCommands();
		if (!timedOut)
			systemLatchWrites();
		if (!timedOut)
			unmappedAndStall();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: source/neoIoTop.sv
`timescale 1ns/1ps

`include "neoIoSettings.svh"

module neoIoTop (
	input  logic CLK_24M,
	input  logic arstN,
	input  logic hostReq,
	output logic hostAck,
	input  neoIoPkg::busCmdT hostCmd,
	output neoIoPkg::busRspT hostRsp,
	input  logic [`JOY_WIDTH-1:0] p1In,
	input  logic [`JOY_WIDTH-1:0] p2In,
	input  logic [`DIP_WIDTH-1:0] dipSw,
	input  logic testBtn,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [2:0] cardBank,
	output logic [2:0] slot,
	output logic [2:0] ledLatch,
	output logic [7:0] ledData,
	output logic [1:0] counters,
	output logic [1:0] lockouts,
	output neoIoPkg::sysFlagsT sysFlags
);
	import neoIoPkg::*;

	// Decode to register stage
	logic decodeReq, decodeAck;
	decodedAccessT decodeOut;
	// Register to response stage
	logic accessReq, accessAck;
	busRspT accessRsp;

	// hostAck loops back so decode holds off until the access closes
	busDecode decode (.CLK_24M, .arstN, .hostReq, .hostAckSeen(hostAck), .hostCmd,
		.decodeReq, .decodeAck, .decodeOut);

	ioRegisters regs (.CLK_24M, .arstN, .decodeReq, .decodeAck, .decodeOut,
		.accessReq, .accessAck, .accessRsp, .p1In, .p2In, .dipSw, .testBtn,
		.p1Out, .p2Out, .cardBank, .slot, .ledLatch, .ledData, .counters, .lockouts,
		.sysFlags);

	busResponse response (.CLK_24M, .arstN, .accessReq, .accessAck, .accessRsp,
		.hostReq, .hostAck, .hostRsp);

endmodule

// File: source/busResponse.sv
`timescale 1ns/1ps

module busResponse (
	input  logic CLK_24M,
	input  logic arstN,
	input  logic accessReq,
	output logic accessAck,
	input  neoIoPkg::busRspT accessRsp,
	input  logic hostReq,
	output logic hostAck,
	output neoIoPkg::busRspT hostRsp
);

	logic capture;

	// Only take a new response once the host side has closed
	assign capture = accessReq && !accessAck && !hostAck;

	// Response word, stable for as long as hostAck is high
	always_ff @(posedge CLK_24M) begin
		if (capture)
			hostRsp <= accessRsp;
	end

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			accessAck <= 1'b0;
			hostAck <= 1'b0;
		end else if (capture) begin
			accessAck <= 1'b1;
			hostAck <= 1'b1;
		end else begin
			// Internal link closes as soon as req falls
			if (accessAck && !accessReq)
				accessAck <= 1'b0;
			// Host ack follows hostReq down one cycle later
			if (hostAck && !hostReq)
				hostAck <= 1'b0;
		end
	end

	// Host must still be requesting when the ack comes up
	ackOnlyWithReq: assert property (@(posedge CLK_24M) disable iff (!arstN)
		$rose(hostAck) |-> hostReq);

endmodule

// File: source/ioRegisters.sv
`timescale 1ns/1ps

`include "neoIoSettings.svh"

module ioRegisters (
	input  logic CLK_24M,
	input  logic arstN,
	input  logic decodeReq,
	output logic decodeAck,
	input  neoIoPkg::decodedAccessT decodeOut,
	output logic accessReq,
	input  logic accessAck,
	output neoIoPkg::busRspT accessRsp,
	input  logic [`JOY_WIDTH-1:0] p1In,
	input  logic [`JOY_WIDTH-1:0] p2In,
	input  logic [`DIP_WIDTH-1:0] dipSw,
	input  logic testBtn,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [2:0] cardBank,
	output logic [2:0] slot,
	output logic [2:0] ledLatch,
	output logic [7:0] ledData,
	output logic [1:0] counters,
	output logic [1:0] lockouts,
	output neoIoPkg::sysFlagsT sysFlags
);
	import neoIoPkg::*;

	logic accept;
	logic lowWrite;
	logic counterArea;
	logic wrPoutput, wrCrdBank, wrSlot, wrLedLatch, wrLedData, wrCounter, wrSysLatch;
	logic [`DATA_WIDTH-1:0] rdData;

	// Take a decoded access only when the downstream link is idle
	assign accept = decodeReq && !decodeAck && !accessReq && !accessAck;
	assign lowWrite = accept && decodeOut.write && decodeOut.lowerStrobe;
	assign counterArea = &decodeOut.bitSel.cntView.area;

	// Bit-write strobes, counter area wins over register select
	always_comb begin
		wrPoutput = 1'b0;
		wrCrdBank = 1'b0;
		wrSlot = 1'b0;
		wrLedLatch = 1'b0;
		wrLedData = 1'b0;
		wrCounter = 1'b0;
		if (lowWrite && decodeOut.zone == ZONE_BITWRITE) begin
			if (counterArea)
				wrCounter = 1'b1;
			else
				case (decodeOut.bitSel.regView.regSel)
					3'd0: wrPoutput = 1'b1;
					3'd1: wrCrdBank = 1'b1;
					3'd2: wrSlot = 1'b1;
					3'd3: wrLedLatch = 1'b1;
					3'd4: wrLedData = 1'b1;
					default: ;	// RTC control, not modelled
				endcase
		end
	end
	assign wrSysLatch = lowWrite && decodeOut.zone == ZONE_SYSLATCH;

	// Read mux, undriven lanes float high
	always_comb begin
		rdData = `OPEN_BUS;
		if (!decodeOut.write) begin
			case (decodeOut.zone)
				ZONE_P1DIP: begin
					if (decodeOut.upperStrobe) rdData[15:8] = p1In[7:0];
					if (decodeOut.lowerStrobe) rdData[7:0] = dipSw;
				end
				// Test button is active low on bit 7
				ZONE_STATUSA:
					if (decodeOut.lowerStrobe) rdData[7:0] = {~testBtn, 7'h7F};
				ZONE_P2:
					if (decodeOut.upperStrobe) rdData[15:8] = p2In[7:0];
				ZONE_BITWRITE:
					if (decodeOut.upperStrobe)
						rdData[15:8] = {p2In[`JOY_WIDTH-1 -: 2], p1In[`JOY_WIDTH-1 -: 2], 4'hF};
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (accept) begin
			accessRsp.hit <= decodeOut.zone != ZONE_UNMAPPED;
			accessRsp.rdData <= rdData;
		end
	end

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			decodeAck <= 1'b0;
			accessReq <= 1'b0;
			{p1Out, p2Out, cardBank, slot, ledLatch, ledData, counters, lockouts} <= '0;
		end else begin
			// Upstream handshake
			if (accept) decodeAck <= 1'b1;
			else if (decodeAck && !decodeReq) decodeAck <= 1'b0;
			// Downstream handshake
			if (accept) accessReq <= 1'b1;
			else if (accessReq && accessAck) accessReq <= 1'b0;
			if (wrPoutput) {p2Out, p1Out} <= decodeOut.wrData[5:0];
			if (wrCrdBank) cardBank <= decodeOut.wrData[2:0];
			if (wrSlot) slot <= decodeOut.wrData[2:0];
			if (wrLedLatch) ledLatch <= decodeOut.wrData[5:3];
			if (wrLedData) ledData <= decodeOut.wrData[7:0];
			if (wrCounter) begin
				if (decodeOut.bitSel.cntView.lockSel)
					lockouts[decodeOut.bitSel.cntView.playerSel] <= decodeOut.bitSel.cntView.setBit;
				else
					counters[decodeOut.bitSel.cntView.playerSel] <= decodeOut.bitSel.cntView.setBit;
			end
		end
	end

	systemLatch sysLatch (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.wrEn(wrSysLatch),
		.bitSel(decodeOut.latchBits[2:0]),
		.bitValue(decodeOut.latchBits[3]),
		.sysFlags(sysFlags)
	);

	// One output register group at most changes per cycle
	oneWritePerCycle: assert property (@(posedge CLK_24M) disable iff (!arstN)
		$onehot0({$changed({p1Out, p2Out}), $changed(cardBank), $changed(slot),
			$changed(ledLatch), $changed(ledData), $changed({counters, lockouts}),
			$changed(sysFlags)}));

endmodule

// File: source/busDecode.sv
`timescale 1ns/1ps

module busDecode (
	input  logic CLK_24M,
	input  logic arstN,
	input  logic hostReq,
	input  logic hostAckSeen,
	input  neoIoPkg::busCmdT hostCmd,
	output logic decodeReq,
	input  logic decodeAck,
	output neoIoPkg::decodedAccessT decodeOut
);
	import neoIoPkg::*;

	// Payload registered, decodeReq goes up next cycle
	logic loaded;
	// This host request was already taken
	logic taken;
	logic accept;
	ioZoneT zone;

	// Stage idle and host side not yet acknowledged
	assign accept = hostReq && !hostAckSeen && !taken &&
		!loaded && !decodeReq && !decodeAck;

	// Zone from A21..A17, A23 and A22 are ignored
	always_comb begin
		case (hostCmd.addr[20:16])
			5'b11000: zone = ZONE_P1DIP;
			5'b11001: zone = ZONE_STATUSA;
			5'b11010: zone = ZONE_P2;
			5'b11100: zone = ZONE_BITWRITE;
			5'b11101: zone = ZONE_SYSLATCH;
			default:  zone = ZONE_UNMAPPED;
		endcase
	end

	// Payload only, held until the next accept
	always_ff @(posedge CLK_24M) begin
		if (accept) begin
			decodeOut.zone <= zone;
			decodeOut.write <= hostCmd.write;
			decodeOut.upperStrobe <= hostCmd.upperStrobe;
			decodeOut.lowerStrobe <= hostCmd.lowerStrobe;
			decodeOut.wrData <= hostCmd.wrData;
			decodeOut.bitSel <= bitWriteSelU'(hostCmd.addr[6:0]);
			decodeOut.latchBits <= hostCmd.addr[3:0];
		end
	end

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			loaded <= 1'b0;
			taken <= 1'b0;
			decodeReq <= 1'b0;
		end else begin
			if (accept) begin
				loaded <= 1'b1;
				taken <= 1'b1;
			end else if (!hostReq) begin
				taken <= 1'b0;
			end
			// Raise req one cycle after capture
			if (loaded && !decodeAck) begin
				decodeReq <= 1'b1;
				loaded <= 1'b0;
			end else if (decodeReq && decodeAck) begin
				decodeReq <= 1'b0;
			end
		end
	end

	// Next transfer waits for the previous ack to fall
	reqAfterAckLow: assert property (@(posedge CLK_24M) disable iff (!arstN)
		$rose(decodeReq) |-> !decodeAck);

endmodule

// File: source/systemLatch.sv
`timescale 1ns/1ps

module systemLatch (
	input  logic CLK_24M,
	input  logic arstN,
	input  logic wrEn,
	input  logic [2:0] bitSel,
	input  logic bitValue,
	output neoIoPkg::sysFlagsT sysFlags
);

	// Flag store, index 0 is shadow and index 7 is palette bank
	logic [7:0] flags;

	// Behaves like an LS259, one bit per write
	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			flags <= 8'h00;
		end else if (wrEn) begin
			// Other seven flags keep their state
			flags[bitSel] <= bitValue;
		end
	end

	assign sysFlags = flags;

	// Write enable comes from the register stage decode
	wrEnKnown: assert property (@(posedge CLK_24M) disable iff (!arstN)
		!$isunknown(wrEn));

endmodule

// File: source/neoIoPkg.sv
`include "neoIoSettings.svh"

package neoIoPkg;

	// One 68000 bus access as issued by the host
	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] addr;
		logic write;
		logic upperStrobe;
		logic lowerStrobe;
		logic [`DATA_WIDTH-1:0] wrData;
	} busCmdT;

	// I/O zones under the 0x3E mask
	typedef enum logic [2:0] {
		ZONE_P1DIP    = 3'd0,	// 0x30xxxx
		ZONE_STATUSA  = 3'd1,	// 0x32xxxx, sound latch and STATUS_A
		ZONE_P2       = 3'd2,	// 0x34xxxx
		ZONE_BITWRITE = 3'd3,	// 0x38xxxx, STATUS_B and bit-writes
		ZONE_SYSLATCH = 3'd4,	// 0x3Axxxx
		ZONE_UNMAPPED = 3'd5
	} ioZoneT;

	// Low address bits A7 to A1, seen two ways
	// Register view: A6 to A4 pick the bit-write register
	// Counter view: A6 and A5 both high mean counter area
	typedef union packed {
		struct packed {
			logic a7;
			logic [2:0] regSel;
			logic [2:0] spare;
		} regView;
		struct packed {
			logic a7;
			logic [1:0] area;
			logic setBit;
			logic spare;
			logic lockSel;		// 0 counter, 1 lockout
			logic playerSel;	// 0 player 1, 1 player 2
		} cntView;
	} bitWriteSelU;

	// Decoded access handed from the decode stage to the register stage
	typedef struct packed {
		ioZoneT zone;
		logic write;
		logic upperStrobe;
		logic lowerStrobe;
		logic [`DATA_WIDTH-1:0] wrData;
		bitWriteSelU bitSel;
		logic [3:0] latchBits;	// A4 value, A3..A1 index
	} decodedAccessT;

	// Response, hit is low for unmapped zones
	typedef struct packed {
		logic hit;
		logic [`DATA_WIDTH-1:0] rdData;
	} busRspT;

	// System latch outputs, shadow sits at index 0
	typedef struct packed {
		logic palBank;
		logic sramWeN;
		logic systemN;
		logic regEnN;
		logic cardWeB;
		logic cardWeN;
		logic vecN;
		logic shadow;
	} sysFlagsT;

endpackage

// File: source/neoIoSettings.svh
`ifndef NEO_IO_SETTINGS_SVH
`define NEO_IO_SETTINGS_SVH

// 68000 word address, bits A23 down to A1
`define ADDR_WIDTH 23

// 68000 data bus
`define DATA_WIDTH 16

// Joypad port, eight buttons plus two extra lines
`define JOY_WIDTH 10

// DIP switch bank
`define DIP_WIDTH 8

// Value seen on the data bus when nothing drives it
`define OPEN_BUS 16'hFFFF

`endif
